// File: Makefile
# Verilator build and run for the I3C controller testbench

VERILATOR ?= verilator
TOP       ?= i3c_ctrl_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= project.f
VFLAGS    ?= --binary --timing --assert
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST)) hdl/i3c_ctrl_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/i3c_bit_serializer.sv
// Bit-time generator driving SCL and SDA for each bit kind and sampling the ACK slot
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

module i3c_bit_serializer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    bit_start,
  input  i3c_ctrl_pkg::bit_kind_e bit_kind,
  input  logic                    bit_val,
  output logic                    bit_done,
  output logic                    ack_seen,
  input  logic                    sda_in,
  output logic                    scl,
  output logic                    sda_out,
  output logic                    sda_oe
);

  import i3c_ctrl_pkg::*;

  localparam int HalfBit = `I3C_HALF_BIT;
  localparam int CntW    = (HalfBit > 1) ? $clog2(HalfBit) : 1;
  // START/STOP edge sits in the middle of the SCL-high half
  localparam int SdaMid  = HalfBit / 2;

  bit_kind_e       kind_q;
  logic            active;
  logic            phase;  // 0 low half, 1 high half
  logic [CntW-1:0] half_cnt;
  logic            half_last;
  logic            rise_now;
  logic            sda_edge;

  assign half_last = (half_cnt == CntW'(HalfBit - 1));
  assign rise_now  = active && !phase && half_last;
  assign sda_edge  = (SdaMid == 0) ? rise_now
                                   : (active && phase && (int'(half_cnt) == SdaMid - 1));
  assign bit_done  = active && phase && half_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kind_q   <= bk_stop;
      active   <= 1'b0;
      phase    <= 1'b0;
      half_cnt <= '0;
      scl      <= 1'b1;
      sda_out  <= 1'b1;
      sda_oe   <= 1'b1;
      ack_seen <= 1'b0;
    end else if (bit_start) begin
      // SCL falls and data SDA settles on the same edge
      kind_q   <= bit_kind;
      active   <= 1'b1;
      phase    <= 1'b0;
      half_cnt <= '0;
      scl      <= 1'b0;
      sda_oe   <= (bit_kind != bk_release);
      case (bit_kind)
        bk_data: sda_out <= bit_val;
        bk_stop: sda_out <= 1'b0;
        default: sda_out <= 1'b1;
      endcase
    end else if (active) begin
      if (half_last) begin
        half_cnt <= '0;
        if (!phase) begin
          phase <= 1'b1;
          scl   <= 1'b1;
          if (kind_q == bk_release) begin
            ack_seen <= sda_in;
          end
        end else begin
          // Bit over, SCL stays high until the next bit
          active <= 1'b0;
        end
      end else begin
        half_cnt <= half_cnt + CntW'(1);
      end

      if (sda_edge) begin
        if (kind_q == bk_start) begin
          sda_out <= 1'b0;
        end else if (kind_q == bk_stop) begin
          sda_out <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/i3c_ctrl_cfg.svh
// I3C controller build options for bus width, bit timing and arbitration
`ifndef I3C_CTRL_CFG_SVH
`define I3C_CTRL_CFG_SVH

// Wishbone write data: [14:8] target address, [7:0] data byte, [15] unused
`define I3C_WB_DW 16

// 7-bit static target address
`define I3C_ADDR_W 7

// Clock cycles per SCL half-period, one bit time is twice this
`define I3C_HALF_BIT 2

// Tie-break between the two masters
// 1 gives round-robin, 0 always favors master 0
`define I3C_ARB_RR 1

`endif

// File: hdl/i3c_ctrl_pkg.sv
// Shared types for the I3C SDR transmit path
`default_nettype none

`include "i3c_ctrl_cfg.svh"

package i3c_ctrl_pkg;

  // One private write as taken from the granted bus
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } i3c_cmd_t;

  // What the serializer plays during one bit time
  typedef enum logic [1:0] {
    bk_start,
    bk_data,
    bk_release,  // ACK slot, line left to the target
    bk_stop
  } bit_kind_e;

  // Frame sequencer states
  typedef enum logic [2:0] {
    fs_idle,
    fs_start,
    fs_addr,
    fs_ack,
    fs_data,
    fs_par,
    fs_stop,
    fs_resp
  } frame_state_e;

endpackage

`default_nettype wire

// File: hdl/i3c_ctrl_top.sv
// I3C SDR controller transmit path with two Wishbone master ports
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

module i3c_ctrl_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  m0_cyc,
  input  logic                  m0_stb,
  input  logic                  m0_we,
  input  logic [`I3C_WB_DW-1:0] m0_dat_w,
  output logic                  m0_ack,
  output logic                  m0_err,
  input  logic                  m1_cyc,
  input  logic                  m1_stb,
  input  logic                  m1_we,
  input  logic [`I3C_WB_DW-1:0] m1_dat_w,
  output logic                  m1_ack,
  output logic                  m1_err,
  output logic                  scl,
  output logic                  sda_out,
  output logic                  sda_oe,
  input  logic                  sda_in
);

  import i3c_ctrl_pkg::*;

  i3c_wb_if wb_m0 ();
  i3c_wb_if wb_m1 ();
  i3c_wb_if wb_gnt ();

  logic      bit_start;
  bit_kind_e bit_kind;
  logic      bit_val;
  logic      bit_done;
  logic      ack_seen;

  // Master port 0
  assign wb_m0.cyc   = m0_cyc;
  assign wb_m0.stb   = m0_stb;
  assign wb_m0.we    = m0_we;
  assign wb_m0.dat_w = m0_dat_w;
  assign m0_ack      = wb_m0.ack;
  assign m0_err      = wb_m0.err;

  // Master port 1
  assign wb_m1.cyc   = m1_cyc;
  assign wb_m1.stb   = m1_stb;
  assign wb_m1.we    = m1_we;
  assign wb_m1.dat_w = m1_dat_w;
  assign m1_ack      = wb_m1.ack;
  assign m1_err      = wb_m1.err;

  i3c_wb_arbiter u_arb (
    .clk   (clk),
    .rst_n (rst_n),
    .s0    (wb_m0.slave),
    .s1    (wb_m1.slave),
    .m     (wb_gnt.master)
  );

  i3c_sdr_pkt_gen u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb        (wb_gnt.slave),
    .bit_start (bit_start),
    .bit_kind  (bit_kind),
    .bit_val   (bit_val),
    .bit_done  (bit_done),
    .ack_seen  (ack_seen)
  );

  i3c_bit_serializer u_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .bit_start (bit_start),
    .bit_kind  (bit_kind),
    .bit_val   (bit_val),
    .bit_done  (bit_done),
    .ack_seen  (ack_seen),
    .sda_in    (sda_in),
    .scl       (scl),
    .sda_out   (sda_out),
    .sda_oe    (sda_oe)
  );

endmodule

`default_nettype wire

// File: hdl/i3c_sdr_pkt_gen.sv
// SDR frame sequencer turning one granted write into bit requests and a bus response
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

module i3c_sdr_pkt_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  i3c_wb_if.slave                wb,
  output logic                   bit_start,
  output i3c_ctrl_pkg::bit_kind_e bit_kind,
  output logic                   bit_val,
  input  logic                   bit_done,
  input  logic                   ack_seen
);

  import i3c_ctrl_pkg::*;

  frame_state_e state;
  frame_state_e state_d;
  logic [2:0]   cnt;
  logic [2:0]   cnt_d;
  logic         resp_err;
  logic         resp_err_d;
  i3c_cmd_t     cmd;
  i3c_cmd_t     cmd_d;
  // Outgoing byte, MSB already on the line
  logic [7:0]   sh;
  logic [7:0]   sh_d;

  // Next bit is requested in the bit_done cycle, so bits run back to back
  always_comb begin
    state_d    = state;
    cnt_d      = cnt;
    resp_err_d = resp_err;
    cmd_d      = cmd;
    sh_d       = sh;
    bit_start  = 1'b0;
    bit_kind   = bk_data;
    bit_val    = 1'b1;

    case (state)
      fs_idle: begin
        if (wb.cyc && wb.stb) begin
          if (wb.we) begin
            cmd_d      = i3c_cmd_t'(wb.dat_w[`I3C_ADDR_W+7:0]);
            resp_err_d = 1'b0;
            state_d    = fs_start;
            bit_start  = 1'b1;
            bit_kind   = bk_start;
          end else begin
            // Reads are not supported
            resp_err_d = 1'b1;
            state_d    = fs_resp;
          end
        end
      end

      fs_start: begin
        if (bit_done) begin
          // Address MSB first, RnW low last
          state_d   = fs_addr;
          cnt_d     = 3'd0;
          bit_start = 1'b1;
          bit_val   = cmd.addr[`I3C_ADDR_W-1];
          sh_d      = {cmd.addr[`I3C_ADDR_W-2:0], 1'b0, 1'b0};
        end
      end

      fs_addr: begin
        if (bit_done) begin
          bit_start = 1'b1;
          if (cnt == 3'd7) begin
            state_d  = fs_ack;
            bit_kind = bk_release;
          end else begin
            cnt_d   = cnt + 3'd1;
            bit_val = sh[7];
            sh_d    = {sh[6:0], 1'b0};
          end
        end
      end

      fs_ack: begin
        if (bit_done) begin
          bit_start = 1'b1;
          if (ack_seen) begin
            // NACK, close the frame at once
            state_d    = fs_stop;
            resp_err_d = 1'b1;
            bit_kind   = bk_stop;
            bit_val    = 1'b0;
          end else begin
            state_d = fs_data;
            cnt_d   = 3'd0;
            bit_val = cmd.data[7];
            sh_d    = {cmd.data[6:0], 1'b0};
          end
        end
      end

      fs_data: begin
        if (bit_done) begin
          bit_start = 1'b1;
          if (cnt == 3'd7) begin
            // T bit makes the ones count odd
            state_d = fs_par;
            bit_val = ~^cmd.data;
          end else begin
            cnt_d   = cnt + 3'd1;
            bit_val = sh[7];
            sh_d    = {sh[6:0], 1'b0};
          end
        end
      end

      fs_par: begin
        if (bit_done) begin
          state_d   = fs_stop;
          bit_start = 1'b1;
          bit_kind  = bk_stop;
          bit_val   = 1'b0;
        end
      end

      fs_stop: begin
        if (bit_done) begin
          state_d = fs_resp;
        end
      end

      fs_resp: begin
        state_d = fs_idle;
      end

      default: begin
        state_d = fs_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= fs_idle;
      cnt      <= 3'd0;
      resp_err <= 1'b0;
    end else begin
      state    <= state_d;
      cnt      <= cnt_d;
      resp_err <= resp_err_d;
    end
  end

  always_ff @(posedge clk) begin
    cmd <= cmd_d;
    sh  <= sh_d;
  end

  // Response lands one cycle after the last STOP cycle
  assign wb.ack = (state == fs_resp) && !resp_err;
  assign wb.err = (state == fs_resp) && resp_err;

endmodule

`default_nettype wire

// File: hdl/i3c_wb_arbiter.sv
// Round-robin arbiter joining two Wishbone masters onto one granted bus
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

module i3c_wb_arbiter (
  input logic      clk,
  input logic      rst_n,
  i3c_wb_if.slave  s0,
  i3c_wb_if.slave  s1,
  i3c_wb_if.master m
);

  localparam bit RoundRobin = `I3C_ARB_RR;

  logic req0;
  logic req1;
  logic gnt_valid;
  // Last grant, also selects the current owner while gnt_valid is high
  logic gnt_sel;
  logic busy;
  logic win_sel;

  assign req0 = s0.cyc && s0.stb;
  assign req1 = s1.cyc && s1.stb;

  // Owner keeps the bus for as long as it holds cyc
  assign busy = gnt_valid && (gnt_sel ? s1.cyc : s0.cyc);

  // Tie goes to whoever lost last time
  always_comb begin
    if (req0 && req1) begin
      win_sel = RoundRobin ? !gnt_sel : 1'b0;
    end else begin
      win_sel = req1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_valid <= 1'b0;
      gnt_sel   <= 1'b1;  // so the first tie favors m0
    end else if (!busy) begin
      gnt_valid <= req0 || req1;
      if (req0 || req1) begin
        gnt_sel <= win_sel;
      end
    end
  end

  // Downstream sees only the owner
  assign m.cyc   = busy;
  assign m.stb   = gnt_valid && (gnt_sel ? s1.stb : s0.stb);
  assign m.we    = gnt_sel ? s1.we : s0.we;
  assign m.dat_w = gnt_sel ? s1.dat_w : s0.dat_w;

  // Responses go back to the owner only
  assign s0.ack = gnt_valid && !gnt_sel && m.ack;
  assign s0.err = gnt_valid && !gnt_sel && m.err;
  assign s1.ack = gnt_valid && gnt_sel && m.ack;
  assign s1.err = gnt_valid && gnt_sel && m.err;

endmodule

`default_nettype wire

// File: hdl/i3c_wb_if.sv
// Write-only Wishbone classic bus between the masters, arbiter and sequencer
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

interface i3c_wb_if;

  // Request side, held steady until ack or err
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`I3C_WB_DW-1:0] dat_w;

  // Response side, one-cycle pulses, never both high
  logic                  ack;
  logic                  err;

  modport master (
    output cyc,
    output stb,
    output we,
    output dat_w,
    input  ack,
    input  err
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  dat_w,
    output ack,
    output err
  );

endinterface

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/i3c_ctrl_pkg.sv
hdl/i3c_wb_if.sv
hdl/i3c_wb_arbiter.sv
hdl/i3c_sdr_pkt_gen.sv
hdl/i3c_bit_serializer.sv
hdl/i3c_ctrl_top.sv
tests/i3c_ctrl_props.sv
tests/i3c_ctrl_tb.sv

// File: tests/i3c_ctrl_props.sv
// Bound protocol checks on the I3C line and the Wishbone responses
`timescale 1ns/10ps
`default_nettype none

module i3c_ctrl_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    m0_cyc,
  input logic                    m0_stb,
  input logic                    m0_ack,
  input logic                    m0_err,
  input logic                    m1_cyc,
  input logic                    m1_stb,
  input logic                    m1_ack,
  input logic                    m1_err,
  input logic                    scl,
  input logic                    sda_out,
  input logic                    sda_oe,
  input logic                    sda_in,
  input i3c_ctrl_pkg::bit_kind_e kind
);

  import i3c_ctrl_pkg::*;

  int   prop_fails = 0;
  logic line;

  // Wired SDA as seen by the target
  assign line = sda_oe ? sda_out : sda_in;

  a_resp_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(m0_ack && m0_err) && !(m1_ack && m1_err))
  else begin
    $error("ack and err high together");
    prop_fails++;
  end

  a_resp_m0: assert property (@(posedge clk) disable iff (!rst_n)
    (m0_ack || m0_err) |-> (m0_cyc && m0_stb))
  else begin
    $error("m0 response without cyc and stb");
    prop_fails++;
  end

  a_resp_m1: assert property (@(posedge clk) disable iff (!rst_n)
    (m1_ack || m1_err) |-> (m1_cyc && m1_stb))
  else begin
    $error("m1 response without cyc and stb");
    prop_fails++;
  end

  // SDA moves under high SCL only as START (fall) or STOP (rise)
  a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (scl && $past(scl) && (line != $past(line))) |->
      ((kind == bk_start && !line) || (kind == bk_stop && line)))
  else begin
    $error("SDA changed while SCL high outside START or STOP");
    prop_fails++;
  end

  a_reset_idle: assert property (@(posedge clk)
    (rst_n && !$past(rst_n)) |->
      (scl && sda_out && sda_oe && !m0_ack && !m0_err && !m1_ack && !m1_err))
  else begin
    $error("bus not idle after reset");
    prop_fails++;
  end

endmodule

bind i3c_ctrl_top i3c_ctrl_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .m0_cyc  (m0_cyc),
  .m0_stb  (m0_stb),
  .m0_ack  (m0_ack),
  .m0_err  (m0_err),
  .m1_cyc  (m1_cyc),
  .m1_stb  (m1_stb),
  .m1_ack  (m1_ack),
  .m1_err  (m1_err),
  .scl     (scl),
  .sda_out (sda_out),
  .sda_oe  (sda_oe),
  .sda_in  (sda_in),
  .kind    (u_ser.kind_q)
);

`default_nettype wire

// File: tests/i3c_ctrl_tb.sv
// Testbench for the I3C SDR controller with two masters, a target and a bus decoder
`timescale 1ns/10ps
`default_nettype none

`include "i3c_ctrl_cfg.svh"

module i3c_ctrl_tb;

  typedef struct {
    logic [6:0] addr;
    logic       rnw;
    logic [7:0] data;
    logic       t;
    int         len;
  } frame_t;

  logic                  clk;
  logic                  rst_n;
  logic                  m0_cyc;
  logic                  m0_stb;
  logic                  m0_we;
  logic [`I3C_WB_DW-1:0] m0_dat_w;
  logic                  m0_ack;
  logic                  m0_err;
  logic                  m1_cyc;
  logic                  m1_stb;
  logic                  m1_we;
  logic [`I3C_WB_DW-1:0] m1_dat_w;
  logic                  m1_ack;
  logic                  m1_err;
  logic                  scl;
  logic                  sda_out;
  logic                  sda_oe;
  logic                  sda_in;
  logic                  line;
  logic                  nack_addr;
  logic                  prev_scl;
  logic                  prev_line;
  logic                  in_frame;
  logic [31:0]           fb;
  int                    nbits;
  frame_t                got_q[$];
  frame_t                exp_q[$];
  int                    errors;
  int                    fails;
  int                    tests;
  int                    start_cnt;
  int                    ack_cnt[2];
  int                    err_cnt[2];
  logic [31:0]           rng;
  bit                    last_gnt;

  i3c_ctrl_top dut (
    .clk(clk), .rst_n(rst_n),
    .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_dat_w(m0_dat_w),
    .m0_ack(m0_ack), .m0_err(m0_err),
    .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_dat_w(m1_dat_w),
    .m1_ack(m1_ack), .m1_err(m1_err),
    .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe), .sda_in(sda_in)
  );

  always #20 clk = ~clk;

  assign line = sda_oe ? sda_out : sda_in;

  // Target acks even addresses during the ACK slot
  always @(posedge clk) begin
    sda_in <= sda_oe ? 1'b1 : nack_addr;
  end

  always @(negedge clk) begin
    if (m0_ack) ack_cnt[0]++;
    if (m0_err) err_cnt[0]++;
    if (m1_ack) ack_cnt[1]++;
    if (m1_err) err_cnt[1]++;
  end

  // Bus decoder with fb[0] holding the first bit after START
  always @(posedge clk) begin
    frame_t f;
    if (!rst_n) begin
      prev_scl  <= 1'b1;
      prev_line <= 1'b1;
      in_frame  <= 1'b0;
      nbits     <= 0;
      nack_addr <= 1'b1;
    end else begin
      prev_scl  <= scl;
      prev_line <= line;
      if (scl && prev_scl && prev_line && !line) begin
        in_frame <= 1'b1;
        nbits    <= 0;
        start_cnt++;
      end else if (scl && prev_scl && !prev_line && line && in_frame) begin
        // Last sample was the STOP bit itself
        f.len = nbits + 1;
        for (int i = 0; i < 7; i++) f.addr[6-i] = fb[i];
        f.rnw  = fb[7];
        f.data = '0;
        f.t    = 1'b0;
        if (nbits >= 19) begin
          for (int i = 0; i < 8; i++) f.data[7-i] = fb[9+i];
          f.t = fb[17];
        end
        got_q.push_back(f);
        in_frame <= 1'b0;
      end else if (scl && !prev_scl && in_frame) begin
        fb[nbits] <= line;
        nbits     <= nbits + 1;
        if (nbits == 7) nack_addr <= fb[6];
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Odd addresses are NACKed, so only 11 bit times go out
  function automatic frame_t expect_frame(input logic [15:0] dat);
    frame_t f;
    f.addr = dat[14:8];
    f.rnw  = 1'b0;
    f.len  = dat[8] ? 11 : 20;
    f.data = dat[8] ? 8'h00 : dat[7:0];
    f.t    = dat[8] ? 1'b0 : ($countones(dat[7:0]) % 2 == 0);
    return f;
  endfunction

  function automatic bit same_frame(input frame_t a, input frame_t b);
    return a.addr == b.addr && a.rnw == b.rnw && a.len == b.len && a.data == b.data
           && a.t == b.t;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_frame(input frame_t e, input frame_t g);
    check_val("frame.addr", e.addr, g.addr);
    check_val("frame.rnw", e.rnw, g.rnw);
    check_val("frame.len", e.len, g.len);
    check_val("frame.data", e.data, g.data);
    check_val("frame.t", e.t, g.t);
  endtask

  task automatic post_write(input int idx, input logic we, input logic [15:0] dat);
    int   n;
    logic got_ack;
    logic got_err;
    logic exp_err;
    exp_err = !we || dat[8];
    if (idx == 0) begin
      m0_cyc   <= 1'b1;
      m0_stb   <= 1'b1;
      m0_we    <= we;
      m0_dat_w <= dat;
    end else begin
      m1_cyc   <= 1'b1;
      m1_stb   <= 1'b1;
      m1_we    <= we;
      m1_dat_w <= dat;
    end
    got_ack = 1'b0;
    got_err = 1'b0;
    n = 0;
    while (!got_ack && !got_err && n < 1000) begin
      @(posedge clk);
      got_ack = (idx == 0) ? m0_ack : m1_ack;
      got_err = (idx == 0) ? m0_err : m1_err;
      n++;
    end
    if (idx == 0) begin
      m0_cyc <= 1'b0;
      m0_stb <= 1'b0;
    end else begin
      m1_cyc <= 1'b0;
      m1_stb <= 1'b0;
    end
    if (!got_ack && !got_err) begin
      $display("Timeout: master %0d got no response to its write", idx);
      errors++;
    end else begin
      check_val($sformatf("m%0d_err", idx), exp_err, got_err);
      check_val($sformatf("m%0d_ack", idx), !exp_err, got_ack);
    end
  endtask

  task automatic wait_frames(input int count);
    int n;
    n = 0;
    while (got_q.size() < count && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (got_q.size() < count) begin
      $display("Timeout: only %0d of %0d frames seen on the bus", got_q.size(), count);
      errors++;
    end
  endtask

  task automatic check_in_order();
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      compare_frame(exp_q.pop_front(), got_q.pop_front());
    end
    check_val("frames_left", 0, exp_q.size() + got_q.size());
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail", name);
      fails++;
    end
  endtask

  initial begin
    int          e;
    int          s;
    int          a0;
    int          a1;
    int          f0;
    int          f1;
    bit          found;
    logic [15:0] d0[2];
    logic [15:0] d1[2];
    logic [15:0] r0[8];
    logic [15:0] r1[8];
    int          g0[8];
    int          g1[8];
    clk = 1'b0;
    rst_n = 1'b0;
    {m0_cyc, m0_stb, m0_we, m1_cyc, m1_stb, m1_we} = '0;
    m0_dat_w = '0;
    m1_dat_w = '0;
    sda_in = 1'b1;
    {errors, fails, tests, start_cnt} = '0;
    ack_cnt = '{0, 0};
    err_cnt = '{0, 0};
    rng = 32'd28609;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    e = errors;
    repeat (3) @(posedge clk);
    check_val("scl", 1, scl);
    check_val("sda_out", 1, sda_out);
    check_val("sda_oe", 1, sda_oe);
    check_val("responses", 0, ack_cnt[0] + err_cnt[0] + ack_cnt[1] + err_cnt[1]);
    report_test("test 1 reset idle", e);

    e = errors;
    got_q.delete();
    exp_q.push_back(expect_frame(16'h12A5));
    post_write(0, 1'b1, 16'h12A5);
    wait_frames(1);
    check_in_order();
    check_val("m0_ack count", 1, ack_cnt[0]);
    check_val("m1 responses", 0, ack_cnt[1] + err_cnt[1]);
    last_gnt = 1'b0;
    report_test("test 2 even address write", e);

    e = errors;
    got_q.delete();
    exp_q.push_back(expect_frame(16'h335C));
    post_write(1, 1'b1, 16'h335C);
    wait_frames(1);
    check_in_order();
    check_val("m1_err count", 1, err_cnt[1]);
    check_val("m1_ack count", 0, ack_cnt[1]);
    last_gnt = 1'b1;
    report_test("test 3 odd address nack", e);

    e = errors;
    got_q.delete();
    s = start_cnt;
    post_write(1, 1'b0, 16'h2266);
    repeat (10) @(posedge clk);
    check_val("start count", s, start_cnt);
    check_val("frames", 0, got_q.size());
    last_gnt = 1'b1;
    report_test("test 4 read rejected", e);

    // Tie goes to the master that did not win the last grant
    e = errors;
    got_q.delete();
    d0 = '{16'h2011, 16'h4C3F};
    d1 = '{16'h448E, 16'h0A70};
    for (int r = 0; r < 2; r++) begin
      if (!last_gnt) begin
        exp_q.push_back(expect_frame(d1[r]));
        exp_q.push_back(expect_frame(d0[r]));
      end else begin
        exp_q.push_back(expect_frame(d0[r]));
        exp_q.push_back(expect_frame(d1[r]));
      end
      @(posedge clk);
      fork
        post_write(0, 1'b1, d0[r]);
        post_write(1, 1'b1, d1[r]);
      join
      wait_frames(2);
      check_in_order();
    end
    report_test("test 5 simultaneous requests", e);

    e = errors;
    got_q.delete();
    a0 = ack_cnt[0] + err_cnt[0];
    a1 = ack_cnt[1] + err_cnt[1];
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      r0[i] = rng[15:0];
      g0[i] = 1 + rng[18:16];
      rng = xorshift(rng);
      r1[i] = rng[15:0];
      g1[i] = 1 + rng[18:16];
      exp_q.push_back(expect_frame(r0[i]));
      exp_q.push_back(expect_frame(r1[i]));
    end
    fork
      for (int i = 0; i < 8; i++) begin
        repeat (g0[i]) @(posedge clk);
        post_write(0, 1'b1, r0[i]);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (g1[i]) @(posedge clk);
        post_write(1, 1'b1, r1[i]);
      end
    join
    wait_frames(16);
    // Order between masters depends on arbitration, so match by content
    while (got_q.size() > 0) begin
      found = 1'b0;
      for (int k = 0; k < exp_q.size() && !found; k++) begin
        if (same_frame(exp_q[k], got_q[0])) begin
          exp_q.delete(k);
          found = 1'b1;
        end
      end
      if (!found) begin
        $display("Unexpected frame on the bus with address %0h", got_q[0].addr);
        errors++;
      end
      void'(got_q.pop_front());
    end
    check_val("frames missing", 0, exp_q.size());
    exp_q.delete();
    f0 = ack_cnt[0] + err_cnt[0] - a0;
    f1 = ack_cnt[1] + err_cnt[1] - a1;
    check_val("m0 responses", 8, f0);
    check_val("m1 responses", 8, f1);
    report_test("test 6 random traffic", e);

    errors += dut.u_props.prop_fails;
    $display("tests: %0d, failed: %0d, errors: %0d", tests, fails, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
